/* hw/multiway_pkg.sv */
// Shared types, register map and reset values for the joystick conditioner, imported by its RTL.
package multiway_pkg;

    // A player's digital joystick word or analog stick word.
    // In the digital word bit 0 is right, bit 1 is left, bit 2 is down and bit 3 is up.
    // Bits 15:4 carry the buttons and are never altered by the conditioner.
    // In the analog word bits 7:0 are the horizontal axis and bits 15:8 the vertical axis.
    typedef logic [15:0] joy_word_t;

    // One signed-looking analog axis byte as it arrives from the stick.
    typedef logic [7:0] axis_t;

    // Frame phase within the repeating four-frame duty window.
    typedef logic [1:0] phase_t;

    // AXI4-Lite data and byte address widths.
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_addr_t;

    // Control register.
    // Bit 0 enables the emulation for player 1 and bit 1 for player 2.
    localparam axi_addr_t csr_ctrl_addr = 4'h0;

    // Read-only status register.
    // Bits 1:0 hold the frame phase and bits 15:8 hold the frame count.
    localparam axi_addr_t csr_status_addr = 4'h4;

    // Both players come out of reset with the emulation switched on.
    localparam logic [1:0] ctrl_reset = 2'b11;

    // AXI4-Lite response codes used by the register block.
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

/* hw/frame_phase.sv */
// Frame phase generator: counts rising edges of vertical sync for the duty stage and status register.
`timescale 1ns/1ps

module frame_phase (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 vs,
    output multiway_pkg::phase_t phase,
    output logic [7:0]           frame_count
);

    // Value of vertical sync seen on the previous clock edge.
    logic vs_q;

    // A frame starts when sync is high now but was low one cycle ago.
    logic vs_rise;

    // The edge is found against the registered copy.
    // This makes the counters move on the same edge that samples the new high level.
    assign vs_rise = vs & ~vs_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vs_q        <= 1'b0;
            phase       <= '0;
            frame_count <= '0;
        end else begin
            vs_q <= vs;
            // Both counters wrap naturally at their width.
            // The phase repeats every four frames and the frame count every 256.
            if (vs_rise) begin
                phase       <= phase + 2'd1;
                frame_count <= frame_count + 8'd1;
            end
        end
    end

endmodule

/* hw/stick_duty.sv */
// First pipeline stage: turns analog deflection into per-frame direction candidates for both players.
`timescale 1ns/1ps

module stick_duty (
    input  logic                    clk,
    input  logic                    rst_n,
    input  multiway_pkg::phase_t    phase,
    input  multiway_pkg::joy_word_t raw1,
    input  multiway_pkg::joy_word_t raw2,
    input  multiway_pkg::joy_word_t ana1,
    input  multiway_pkg::joy_word_t ana2,
    output logic [3:0]              cand1,
    output logic [3:0]              cand2,
    output multiway_pkg::joy_word_t raw1_q,
    output multiway_pkg::joy_word_t raw2_q
);

    import multiway_pkg::*;

    // Decides one direction bit from an axis byte v.
    // A set bit 7 means the stick leans the other way, so the raw button wins.
    // Otherwise bits 6:4 select how many of the four frames the direction is held.
    function automatic logic duty_bit(input axis_t v, input logic raw_bit, input phase_t ph);
        logic level;
        case (v[6:4])
            3'd0:    level = raw_bit;
            // One frame out of four.
            3'd1:    level = (ph == 2'd0);
            // Every other frame.
            3'd2:    level = ph[0];
            // Three frames out of four.
            3'd3:    level = (ph != 2'd0);
            // Full deflection holds the direction on.
            default: level = 1'b1;
        endcase
        if (v[7]) begin
            level = raw_bit;
        end
        return level;
    endfunction

    // Builds one direction pair from an axis byte.
    // The lower bit reads the byte as it is.
    // The upper bit reads the inverted byte, so negative deflection maps to the opposite way.
    function automatic logic [1:0] axis_pair(input axis_t v, input logic [1:0] raw_pair,
                                             input phase_t ph);
        return {duty_bit(~v, raw_pair[1], ph), duty_bit(v, raw_pair[0], ph)};
    endfunction

    // The horizontal byte drives bits 1:0 and the vertical byte drives bits 3:2.
    // The raw words are registered next to the candidates to keep buttons aligned.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand1  <= '0;
            cand2  <= '0;
            raw1_q <= '0;
            raw2_q <= '0;
        end else begin
            cand1  <= {axis_pair(ana1[15:8], raw1[3:2], phase),
                       axis_pair(ana1[7:0],  raw1[1:0], phase)};
            cand2  <= {axis_pair(ana2[15:8], raw2[3:2], phase),
                       axis_pair(ana2[7:0],  raw2[1:0], phase)};
            raw1_q <= raw1;
            raw2_q <= raw2;
        end
    end

endmodule

/* hw/dir_resolve.sv */
// Second pipeline stage: removes opposing direction pairs, applies bypass and builds the output words.
`timescale 1ns/1ps

module dir_resolve (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [1:0]              enable,
    input  logic [3:0]              cand1,
    input  logic [3:0]              cand2,
    input  multiway_pkg::joy_word_t raw1_q,
    input  multiway_pkg::joy_word_t raw2_q,
    output multiway_pkg::joy_word_t joy1,
    output multiway_pkg::joy_word_t joy2
);

    import multiway_pkg::*;

    // Output words before the final register.
    joy_word_t next1;
    joy_word_t next2;

    // A pair that presses both opposite directions is treated as no press at all.
    function automatic logic [1:0] clear_conflict(input logic [1:0] pair);
        return (pair == 2'b11) ? 2'b00 : pair;
    endfunction

    // Buttons always come from the raw word.
    // A bypassed player gets the raw word back untouched, conflicts included.
    always_comb begin
        next1 = raw1_q;
        next2 = raw2_q;
        if (enable[0]) begin
            next1[3:0] = {clear_conflict(cand1[3:2]), clear_conflict(cand1[1:0])};
        end
        if (enable[1]) begin
            next2[3:0] = {clear_conflict(cand2[3:2]), clear_conflict(cand2[1:0])};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            joy1 <= '0;
            joy2 <= '0;
        end else begin
            joy1 <= next1;
            joy2 <= next2;
        end
    end

endmodule

/* hw/multiway_csr.sv */
// AXI4-Lite register block: per-player enable control and read-only phase and frame count status.
`timescale 1ns/1ps

module multiway_csr (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    awvalid,
    output logic                    awready,
    input  multiway_pkg::axi_addr_t awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  multiway_pkg::axi_data_t wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  multiway_pkg::axi_addr_t araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output multiway_pkg::axi_data_t rdata,
    output logic [1:0]              rresp,
    input  multiway_pkg::phase_t    phase,
    input  logic [7:0]              frame_count,
    output logic [1:0]              enable
);

    import multiway_pkg::*;

    // Each channel is either waiting for a request or holding its response.
    typedef enum logic {wr_idle, wr_resp} wr_state_t;
    typedef enum logic {rd_idle, rd_resp} rd_state_t;

    wr_state_t  wr_state;
    rd_state_t  rd_state;
    logic [1:0] ctrl_q;

    assign enable = ctrl_q;

    // Write channel.
    // Address and data are accepted together in a single-cycle ready pulse.
    // Write strobes are not part of this interface and every write is a full word.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= resp_okay;
            ctrl_q   <= ctrl_reset;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (awready) begin
                        // The handshake completes on this edge.
                        awready  <= 1'b0;
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                        wr_state <= wr_resp;
                        if (awaddr == csr_ctrl_addr) begin
                            ctrl_q <= wdata[1:0];
                            bresp  <= resp_okay;
                        end else if (awaddr == csr_status_addr) begin
                            // Status is read-only and the write is silently dropped.
                            bresp <= resp_okay;
                        end else begin
                            bresp <= resp_slverr;
                        end
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end
                end
                wr_resp: begin
                    // Hold the response until the master takes it.
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // Read channel.
    // Runs independently of the write side so back-pressure on one never stalls the other.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= resp_okay;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (arready) begin
                        arready  <= 1'b0;
                        rvalid   <= 1'b1;
                        rd_state <= rd_resp;
                        if (araddr == csr_ctrl_addr) begin
                            rdata <= {30'd0, ctrl_q};
                            rresp <= resp_okay;
                        end else if (araddr == csr_status_addr) begin
                            rdata <= {16'd0, frame_count, 6'd0, phase};
                            rresp <= resp_okay;
                        end else begin
                            rdata <= '0;
                            rresp <= resp_slverr;
                        end
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end
                rd_resp: begin
                    if (rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

endmodule

/* hw/multiway_top.sv */
// Top level of the joystick conditioner: register block beside the phase, duty and resolve pipeline.
`timescale 1ns/1ps

module multiway_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vs,
    input  multiway_pkg::joy_word_t raw1,
    input  multiway_pkg::joy_word_t raw2,
    input  multiway_pkg::joy_word_t ana1,
    input  multiway_pkg::joy_word_t ana2,
    output multiway_pkg::joy_word_t joy1,
    output multiway_pkg::joy_word_t joy2,
    input  logic                    awvalid,
    output logic                    awready,
    input  multiway_pkg::axi_addr_t awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  multiway_pkg::axi_data_t wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  multiway_pkg::axi_addr_t araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output multiway_pkg::axi_data_t rdata,
    output logic [1:0]              rresp
);

    import multiway_pkg::*;

    // Per-player emulation enable from the control register.
    logic [1:0] enable;

    // Frame timing shared by the duty stage and the status register.
    phase_t     phase;
    logic [7:0] frame_count;

    // Values between the duty stage and the resolver.
    logic [3:0] cand1;
    logic [3:0] cand2;
    joy_word_t  raw1_q;
    joy_word_t  raw2_q;

    multiway_csr multiway_csr_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .phase       (phase),
        .frame_count (frame_count),
        .enable      (enable)
    );

    frame_phase frame_phase_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .vs          (vs),
        .phase       (phase),
        .frame_count (frame_count)
    );

    // Two registered stages, so inputs reach joy1 and joy2 two cycles later.
    stick_duty stick_duty_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .phase  (phase),
        .raw1   (raw1),
        .raw2   (raw2),
        .ana1   (ana1),
        .ana2   (ana2),
        .cand1  (cand1),
        .cand2  (cand2),
        .raw1_q (raw1_q),
        .raw2_q (raw2_q)
    );

    dir_resolve dir_resolve_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .cand1  (cand1),
        .cand2  (cand2),
        .raw1_q (raw1_q),
        .raw2_q (raw2_q),
        .joy1   (joy1),
        .joy2   (joy2)
    );

endmodule

/* dv/multiway_chk.sv */
// Concurrent checks on the AXI4-Lite responses and the conflict rule, bound into the top level.
`timescale 1ns/1ps

module multiway_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready,
    input logic [1:0]              enable,
    input multiway_pkg::joy_word_t joy1,
    input multiway_pkg::joy_word_t joy2
);

    // A write response stays up until the master accepts it.
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    // The same holds for read data.
    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> rvalid)
        else $error("rvalid dropped before rready was seen");

    // The output register was loaded with the enable of the previous cycle.
    // So the conflict rule is tied to the past value of each enable bit.
    joy1_no_conflict: assert property (@(posedge clk) disable iff (!rst_n)
        $past(enable[0]) |-> ((joy1[1:0] != 2'b11) && (joy1[3:2] != 2'b11)))
        else $error("joy1 shows an opposing pair while player 1 is enabled");

    joy2_no_conflict: assert property (@(posedge clk) disable iff (!rst_n)
        $past(enable[1]) |-> ((joy2[1:0] != 2'b11) && (joy2[3:2] != 2'b11)))
        else $error("joy2 shows an opposing pair while player 2 is enabled");

endmodule

bind multiway_top multiway_chk multiway_chk_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .bvalid (bvalid),
    .bready (bready),
    .rvalid (rvalid),
    .rready (rready),
    .enable (enable),
    .joy1   (joy1),
    .joy2   (joy2)
);

/* dv/multiway_tb.sv */
// Self-checking testbench for the joystick conditioner; replays the stimulus file through the top.
`timescale 1ns/1ps

module multiway_tb;

    import multiway_pkg::*;

    // Upper bound on the cycles spent in any single handshake wait.
    localparam int wait_limit = 50;

    logic      clk;
    logic      rst_n;
    logic      vs;
    joy_word_t raw1;
    joy_word_t raw2;
    joy_word_t ana1;
    joy_word_t ana2;
    joy_word_t joy1;
    joy_word_t joy2;
    logic      awvalid;
    logic      awready;
    axi_addr_t awaddr;
    logic      wvalid;
    logic      wready;
    axi_data_t wdata;
    logic      bvalid;
    logic      bready;
    logic [1:0] bresp;
    logic      arvalid;
    logic      arready;
    axi_addr_t araddr;
    logic      rvalid;
    logic      rready;
    axi_data_t rdata;
    logic [1:0] rresp;

    // Number of vs pulses so far, which the frame count and phase must follow.
    logic [7:0] exp_fc;

    multiway_top multiway_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .vs      (vs),
        .raw1    (raw1),
        .raw2    (raw2),
        .ana1    (ana1),
        .ana2    (ana2),
        .joy1    (joy1),
        .joy2    (joy2),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped.");
    endtask

    // Full-word register write; bready is held low at first so bvalid must wait for it.
    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             output logic [1:0] resp);
        int waited;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timed out waiting for the write address and data handshake.");
            end
        end while (!(awready && wready));
        // The handshake completes on the next rising edge.
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timed out waiting for the write response.");
            end
        end
        // One more cycle without bready, so the slave has to keep the response up.
        @(negedge clk);
        check_value("bvalid held", {31'd0, bvalid}, 32'd1);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    // Register read; rready is also held back for a cycle after rvalid rises.
    task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                            output logic [1:0] resp);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timed out waiting for the read address handshake.");
            end
        end while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timed out waiting for read data.");
            end
        end
        @(negedge clk);
        check_value("rvalid held", {31'd0, rvalid}, 32'd1);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // One frame: vs is high for a single clock.
    task automatic pulse_vs();
        vs = 1'b1;
        @(negedge clk);
        vs = 1'b0;
        @(negedge clk);
    endtask

    // Steps frames until the status register reports the wanted phase.
    // Every step also checks that the frame count rose by exactly one.
    task automatic seek_phase(input phase_t target);
        axi_data_t  status;
        logic [1:0] resp;
        int         pulses;
        pulses = 0;
        do begin
            pulse_vs();
            exp_fc = exp_fc + 8'd1;
            axi_read(4'h4, status, resp);
            check_value("status rresp", {30'd0, resp}, 32'd0);
            check_value("frame_count", {24'd0, status[15:8]}, {24'd0, exp_fc});
            check_value("phase", {30'd0, status[1:0]}, {30'd0, exp_fc[1:0]});
            pulses++;
            if (pulses > 8) begin
                abort_run("The frame phase never reached the target value.");
            end
        end while (status[1:0] != target);
    endtask

    initial begin
        int          fd;
        int          fields;
        int          vectors;
        string       line;
        axi_data_t   rd;
        logic [1:0]  resp;
        logic [15:0] en;
        logic [15:0] ph;
        logic [15:0] a1;
        logic [15:0] a2;
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] e1;
        logic [15:0] e2;

        rst_n      = 1'b0;
        vs         = 1'b0;
        raw1       = '0;
        raw2       = '0;
        ana1       = '0;
        ana2       = '0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        exp_fc     = 8'd0;
        vectors    = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Outputs and handshake flags come out of reset cleared.
        check_value("joy1 after reset", {16'd0, joy1}, 32'd0);
        check_value("joy2 after reset", {16'd0, joy2}, 32'd0);
        check_value("awready after reset", {31'd0, awready}, 32'd0);
        check_value("wready after reset", {31'd0, wready}, 32'd0);
        check_value("arready after reset", {31'd0, arready}, 32'd0);
        check_value("bvalid after reset", {31'd0, bvalid}, 32'd0);
        check_value("rvalid after reset", {31'd0, rvalid}, 32'd0);

        // Both players start enabled.
        // Writes to status are dropped and an unmapped address is refused.
        axi_read(4'h0, rd, resp);
        check_value("ctrl after reset", rd, 32'd3);
        check_value("ctrl rresp", {30'd0, resp}, 32'd0);
        axi_read(4'h8, rd, resp);
        check_value("unmapped rresp", {30'd0, resp}, 32'd2);
        axi_write(4'h4, 32'hffff_fffc, resp);
        check_value("status write bresp", {30'd0, resp}, 32'd0);
        axi_write(4'h8, 32'd0, resp);
        check_value("unmapped bresp", {30'd0, resp}, 32'd2);
        axi_read(4'h0, rd, resp);
        check_value("ctrl after ignored writes", rd, 32'd3);

        fd = $fopen("dv/multiway_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file dv/multiway_stimulus.txt.");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h", en, ph, a1, a2, r1, r2, e1, e2);
            if (fields != 8) begin
                abort_run("A line of the stimulus file does not hold eight fields.");
            end
            axi_write(4'h0, {30'd0, en[1:0]}, resp);
            check_value("ctrl bresp", {30'd0, resp}, 32'd0);
            seek_phase(ph[1:0]);
            ana1 = a1;
            ana2 = a2;
            raw1 = r1;
            raw2 = r2;
            // Two pipeline registers, plus one cycle of margin.
            repeat (3) @(negedge clk);
            check_value($sformatf("joy1 vector %0d", vectors), {16'd0, joy1}, {16'd0, e1});
            check_value($sformatf("joy2 vector %0d", vectors), {16'd0, joy2}, {16'd0, e2});
            vectors++;
        end
        $fclose(fd);
        if (vectors == 0) begin
            abort_run("The stimulus file held no vectors.");
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* all.f */
hw/multiway_pkg.sv
hw/frame_phase.sv
hw/stick_duty.sv
hw/dir_resolve.sv
hw/multiway_csr.sv
hw/multiway_top.sv
dv/multiway_chk.sv
dv/multiway_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the joystick conditioner testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module multiway_tb -f all.f -o multiway_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/multiway_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^ALL CHECKS PASSED$"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi

/* dv/multiway_stimulus.txt */
# enable phase ana1 ana2 raw1 raw2 exp_joy1 exp_joy2 (all hex)
# ana words are {vertical byte, horizontal byte}; joy bits 3:0 are up, down, left, right
3 0 1010 b0d0 5a50 1230 5a55 1238
3 1 1010 b0d0 5a50 1230 5a50 123a
3 2 1010 b0d0 5a50 1230 5a50 1238
3 3 1010 b0d0 5a50 1230 5a50 123a
3 0 2020 05f8 5a50 0c06 5a50 0c06
3 1 2020 05f8 5a50 0c06 5a55 0c06
3 2 2020 05f8 5a50 0c06 5a50 0c06
3 3 2020 05f8 5a50 0c06 5a55 0c06
3 0 3030 00e0 5a50 0004 5a50 0006
3 1 3030 00e0 5a50 0004 5a55 0004
3 2 3030 00e0 5a50 0004 5a55 0004
3 3 3030 00e0 5a50 0004 5a55 0004
3 0 4040 0000 5a50 800f 5a55 8000
3 1 4040 0000 5a50 800f 5a55 8000
3 2 4040 0000 5a50 800f 5a55 8000
3 3 4040 0000 5a50 800f 5a55 8000
2 1 4040 0000 0003 0003 0003 0000
1 2 0000 7070 000c 000f 0000 000f
0 3 3030 d0d0 ffff 1234 ffff 1234
3 0 a000 0030 0001 0000 0009 0000
3 3 0040 2000 0002 0000 0000 0004
